//--- all.f
rtl/pe_pkg.sv
rtl/register_pipe.sv
rtl/pe_arith.sv
rtl/pe_dispatch.sv
rtl/pe_collect.sv
rtl/pe_array_top.sv
test/pe_array_chk.sv
test/tb_pe_array.sv

//--- rtl/pe_arith.sv
`timescale 1ns/1ps

module pe_arith #(
    parameter int LATENCY = 4  // half multiply, half add
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  pe_pkg::lane_in_t  i_in,
    input  logic              i_valid,
    input  pe_pkg::op_t       i_op,
    output pe_pkg::lane_out_t o_out,
    output logic              o_res_valid,
    output logic              o_byp_valid
);

    import pe_pkg::*;

    localparam int HALF = LATENCY / 2;  // depth of each stage
    localparam int OPW  = $bits(op_t);

    // multiply stage
    data_t prod;       // a*b before the pipe
    data_t prod_mid;   // product at the add stage input

    // operands delayed to the add stage
    data_t a_mid;
    data_t b_mid;
    data_t c_mid;

    // op code follows the data through both halves
    logic [OPW-1:0] op_mid;  // as seen by the add stage
    logic [OPW-1:0] op_out;  // as seen at the output

    // add stage
    data_t add_x;
    data_t add_y;
    logic  do_sub;
    data_t add_res;
    data_t res_q;

    // bypass of operand a and lane valid
    data_t byp_q;
    logic  byp_valid_q;

    if (LATENCY < 2 || (LATENCY % 2) != 0) begin : g_bad_latency
        $error("pe_arith LATENCY must be even and at least 2");
    end

    assign prod = i_in.a * i_in.b;  // low word only, sign does not matter

    register_pipe #(.WIDTH(DWIDTH), .DEPTH(HALF)) u_mul_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (prod),
        .o_q     (prod_mid)
    );

    // a and b for add/sub, matched to the multiplier
    register_pipe #(.WIDTH(2*DWIDTH), .DEPTH(HALF)) u_ab_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     ({i_in.a, i_in.b}),
        .o_q     ({a_mid, b_mid})
    );

    register_pipe #(.WIDTH(DWIDTH), .DEPTH(HALF)) u_c_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (i_in.c),
        .o_q     (c_mid)
    );

    register_pipe #(.WIDTH(OPW), .DEPTH(HALF)) u_op_mid_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (i_op),
        .o_q     (op_mid)
    );

    register_pipe #(.WIDTH(OPW), .DEPTH(HALF)) u_op_out_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (op_mid),
        .o_q     (op_out)
    );

    // operand select for the shared adder
    always_comb begin
        add_x  = a_mid;
        add_y  = b_mid;
        do_sub = 1'b0;
        case (op_mid)
            OP_SUB:  do_sub = 1'b1;
            OP_MUL: begin
                add_x = prod_mid;
                add_y = '0;  // product passes through unchanged
            end
            OP_MACC: begin
                add_x = prod_mid;
                add_y = c_mid;
            end
            default: ;  // add, nop and spare codes keep a + b
        endcase
    end

    assign add_res = do_sub ? (add_x - add_y) : (add_x + add_y);  // wraps

    register_pipe #(.WIDTH(DWIDTH), .DEPTH(HALF)) u_add_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (add_res),
        .o_q     (res_q)
    );

    // full latency copy of a, carries the lane valid too
    register_pipe #(.WIDTH(DWIDTH+1), .DEPTH(LATENCY)) u_byp_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     ({i_valid, i_in.a}),
        .o_q     ({byp_valid_q, byp_q})
    );

    assign o_out.res    = res_q;
    assign o_out.bypass = byp_q;
    assign o_byp_valid  = byp_valid_q;
    // result only for the four arithmetic codes
    assign o_res_valid  = byp_valid_q && (op_out inside {OP_ADD, OP_SUB, OP_MUL, OP_MACC});

endmodule

//--- rtl/pe_array_top.sv
`timescale 1ns/1ps

module pe_array_top #(
    parameter int N_LANES = 4,  // number of PEs
    parameter int LATENCY = 4   // per PE, even and >= 2
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_valid,
    input  pe_pkg::op_t                      i_op,
    input  logic [N_LANES-1:0]               i_lane_mask,
    input  pe_pkg::lane_in_t [N_LANES-1:0]   i_lanes,
    output pe_pkg::lane_out_t [N_LANES-1:0]  o_lanes,
    output logic [N_LANES-1:0]               o_lane_valid,
    output pe_pkg::sum_t                     o_sum,
    output logic                             o_sum_valid
);

    import pe_pkg::*;

    // dispatcher to PEs
    lane_in_t [N_LANES-1:0] d_lanes;
    op_t                    d_op;
    logic [N_LANES-1:0]     d_valid;

    // PEs to collector
    lane_out_t [N_LANES-1:0] p_out;
    logic [N_LANES-1:0]      p_res_valid;
    logic [N_LANES-1:0]      p_byp_valid;

    pe_dispatch #(.N_LANES(N_LANES)) u_dispatch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_op        (i_op),
        .i_lane_mask (i_lane_mask),
        .i_lanes     (i_lanes),
        .o_lanes     (d_lanes),
        .o_op        (d_op),
        .o_valid     (d_valid)
    );

    // one PE per lane, same op on all
    for (genvar i = 0; i < N_LANES; i++) begin : g_pe
        pe_arith #(.LATENCY(LATENCY)) u_pe (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_in        (d_lanes[i]),
            .i_valid     (d_valid[i]),
            .i_op        (d_op),
            .o_out       (p_out[i]),
            .o_res_valid (p_res_valid[i]),
            .o_byp_valid (p_byp_valid[i])
        );
    end

    pe_collect #(.N_LANES(N_LANES)) u_collect (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_out        (p_out),
        .i_res_valid  (p_res_valid),
        .i_byp_valid  (p_byp_valid),
        .o_lanes      (o_lanes),
        .o_lane_valid (o_lane_valid),
        .o_sum        (o_sum),
        .o_sum_valid  (o_sum_valid)
    );

endmodule

//--- rtl/pe_collect.sv
`timescale 1ns/1ps

module pe_collect #(
    parameter int N_LANES = 4
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  pe_pkg::lane_out_t [N_LANES-1:0]  i_out,
    input  logic [N_LANES-1:0]               i_res_valid,  // from each PE
    input  logic [N_LANES-1:0]               i_byp_valid,
    output pe_pkg::lane_out_t [N_LANES-1:0]  o_lanes,
    output logic [N_LANES-1:0]               o_lane_valid,
    output pe_pkg::sum_t                     o_sum,        // sum of valid results
    output logic                             o_sum_valid
);

    import pe_pkg::*;

    lane_out_t [N_LANES-1:0] lanes_clean;  // res zeroed where not valid
    sum_t                    sum_next;

    // mask the results, then reduce
    // invalid lanes add zero so no second mux is needed in the sum
    always_comb begin
        sum_next = '0;
        for (int i = 0; i < N_LANES; i++) begin
            lanes_clean[i].bypass = i_out[i].bypass;
            lanes_clean[i].res    = i_res_valid[i] ? i_out[i].res : '0;
            sum_next              = sum_next + lanes_clean[i].res;  // wraps
        end
    end

    // valids
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_lane_valid <= '0;
            o_sum_valid  <= 1'b0;
        end else begin
            o_lane_valid <= i_byp_valid;   // lane valid follows the bypass
            o_sum_valid  <= |i_res_valid;  // any result counted
        end
    end

    // payload
    always_ff @(posedge i_clk) begin
        o_lanes <= lanes_clean;
        o_sum   <= sum_next;
    end

endmodule

//--- rtl/pe_dispatch.sv
`timescale 1ns/1ps

module pe_dispatch #(
    parameter int N_LANES = 4
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_valid,      // one vector this cycle
    input  pe_pkg::op_t                     i_op,
    input  logic [N_LANES-1:0]              i_lane_mask,  // lanes taking part
    input  pe_pkg::lane_in_t [N_LANES-1:0]  i_lanes,
    output pe_pkg::lane_in_t [N_LANES-1:0]  o_lanes,
    output pe_pkg::op_t                     o_op,         // broadcast to every PE
    output logic [N_LANES-1:0]              o_valid
);

    import pe_pkg::*;

    logic [N_LANES-1:0] lane_go;  // lanes accepting a vector now

    assign lane_go = {N_LANES{i_valid}} & i_lane_mask;

    // per lane strobes
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= '0;
        end else begin
            o_valid <= lane_go;
        end
    end

    // op code, idles as nop
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_op <= OP_NOP;
        end else if (i_valid) begin
            o_op <= i_op;
        end
    end

    // operand registers
    // a lane outside the mask keeps its old operands, saves toggling
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            if (lane_go[i]) begin
                o_lanes[i] <= i_lanes[i];
            end
        end
    end

endmodule

//--- rtl/pe_pkg.sv
package pe_pkg;

    // datapath width of one integer operand
    localparam int DWIDTH = 32;

    // one two's-complement operand or result, wraps mod 2^DWIDTH
    typedef logic [DWIDTH-1:0] data_t;

    // reduction sum over the lanes, same wrap rule
    typedef logic [DWIDTH-1:0] sum_t;

    // broadcast op code, codes 5..7 act as nop
    typedef enum logic [2:0] {
        OP_ADD  = 3'b000,  // a + b
        OP_SUB  = 3'b001,  // a - b
        OP_MUL  = 3'b010,  // a * b, low word
        OP_MACC = 3'b011,  // a * b + c
        OP_NOP  = 3'b100   // no result
    } op_t;

    // operand triple for one lane
    typedef struct packed {
        data_t a;
        data_t b;
        data_t c;  // addend, only for macc
    } lane_in_t;

    // per lane output word pair
    typedef struct packed {
        data_t res;     // arithmetic result
        data_t bypass;  // operand a after the PE latency
    } lane_out_t;

endpackage

//--- rtl/register_pipe.sv
`timescale 1ns/1ps

module register_pipe #(
    parameter int WIDTH = 1,  // bits per stage
    parameter int DEPTH = 1   // number of register stages
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [WIDTH-1:0] i_d,
    output logic [WIDTH-1:0] o_q
);

    generate
        if (DEPTH == 0) begin : g_wire
            assign o_q = i_d;  // zero delay
        end else begin : g_regs
            logic [WIDTH-1:0] stage_q [DEPTH];  // stage 0 is nearest the input

            always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage_q[i] <= '0;
                    end
                end else begin
                    stage_q[0] <= i_d;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage_q[i] <= stage_q[i-1];  // shift one stage on
                    end
                end
            end

            assign o_q = stage_q[DEPTH-1];  // oldest entry
        end
    endgenerate

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the pe_array testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_pe_array \
    --Mdir obj_dir \
    -f all.f

./obj_dir/Vtb_pe_array | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished clean"

//--- test/pe_array_chk.sv
`timescale 1ns/1ps

module pe_array_chk #(
    parameter int N_LANES = 4,
    parameter int LATENCY = 4
) (
    input logic               i_clk,
    input logic               i_rst_n,
    input logic               i_valid,
    input logic [N_LANES-1:0] i_lane_mask,
    input logic [N_LANES-1:0] o_lane_valid,
    input logic               o_sum_valid
);

    localparam int PIPE = LATENCY + 2;  // dispatch + PE + collect

    logic [N_LANES-1:0] lane_go;  // lanes the dispatcher takes
    int                 run_cnt;  // cycles out of reset, saturates

    assign lane_go = {N_LANES{i_valid}} & i_lane_mask;

    // history must be fully past reset before comparing
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_cnt <= 0;
        end else if (run_cnt < PIPE) begin
            run_cnt <= run_cnt + 1;
        end
    end

    a_sum_has_lane: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_sum_valid |-> (o_lane_valid != '0))
        else $error("o_sum_valid high while no lane is valid");

    a_quiet_in_reset: assert property (@(posedge i_clk)
        !i_rst_n |-> (o_lane_valid == '0 && !o_sum_valid))
        else $error("valid output high during reset");

    a_lane_timing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (run_cnt >= PIPE) |-> (o_lane_valid == $past(lane_go, PIPE)))
        else $error("o_lane_valid differs from valid and mask %0d cycles back", PIPE);

endmodule

bind pe_array_top pe_array_chk #(.N_LANES(N_LANES), .LATENCY(LATENCY)) u_chk (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_lane_mask  (i_lane_mask),
    .o_lane_valid (o_lane_valid),
    .o_sum_valid  (o_sum_valid)
);

//--- test/tb_pe_array.sv
`timescale 1ns/1ps

module tb_pe_array;

    import pe_pkg::*;

    localparam int N_LANES = 4;
    localparam int LATENCY = 4;
    localparam int PIPE    = LATENCY + 2;            // input to output, cycles
    localparam int N_RAND  = 40;
    localparam int N_ROWS  = 11 + N_RAND;            // corner rows first
    localparam int TIMEOUT = N_ROWS + LATENCY + 20;  // covers reset and drain

    typedef lane_in_t [N_LANES-1:0] lanes_t;

    // one stimulus row
    typedef struct packed {
        logic               vld;
        logic [2:0]         op;  // raw code, spare codes allowed
        logic [N_LANES-1:0] mask;
        lanes_t             lanes;
    } row_t;

    // expected outputs for one cycle
    typedef struct packed {
        logic [N_LANES-1:0]  lane_valid;
        logic [N_LANES-1:0]  res_valid;
        data_t [N_LANES-1:0] res;
        data_t [N_LANES-1:0] byp;
        sum_t                sum;
        logic                sum_valid;
    } exp_t;

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_valid;
    op_t                     i_op;
    logic [N_LANES-1:0]      i_lane_mask;
    lanes_t                  i_lanes;
    lane_out_t [N_LANES-1:0] o_lanes;
    logic [N_LANES-1:0]      o_lane_valid;
    sum_t                    o_sum;
    logic                    o_sum_valid;

    row_t rows[$];
    exp_t exp_q[$];  // one entry per cycle in flight
    int   tag_q[$];  // row index, -1 when idle
    int   cyc;
    int   n_checks;
    int   n_errors;
    int   n_tests;

    pe_array_top #(.N_LANES(N_LANES), .LATENCY(LATENCY)) DUT (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_lane_mask  (i_lane_mask),
        .i_lanes      (i_lanes),
        .o_lanes      (o_lanes),
        .o_lane_valid (o_lane_valid),
        .o_sum        (o_sum),
        .o_sum_valid  (o_sum_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;  // 4 ns period
    end

    // hang guard
    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic lane_in_t make_lane(data_t a, data_t b, data_t c);
        lane_in_t l;
        l.a = a;
        l.b = b;
        l.c = c;
        return l;
    endfunction

    // filler operands for rows that test control, not arithmetic
    function automatic lanes_t ramp(data_t base);
        lanes_t l;
        for (int i = 0; i < N_LANES; i++) begin
            l[i] = make_lane(base + data_t'(i), base * 3 + data_t'(i), ~base);
        end
        return l;
    endfunction

    task automatic add_row(input logic vld, input logic [2:0] op,
                           input logic [N_LANES-1:0] mask, input lanes_t lanes);
        row_t r;
        r.vld   = vld;
        r.op    = op;
        r.mask  = mask;
        r.lanes = lanes;
        rows.push_back(r);
    endtask

    // lanes listed 3 down to 0 in the concatenations
    task automatic build_table();
        row_t r;
        add_row(1'b1, OP_ADD, 4'hf, {make_lane(32'h1234_5678, 32'h9abc_def0, 32'h0),
                make_lane(32'h8000_0000, 32'hffff_ffff, 32'h0),
                make_lane(32'hffff_ffff, 32'h1, 32'h0), make_lane(32'h7fff_ffff, 32'h1, 32'h0)});
        add_row(1'b1, OP_SUB, 4'hf, {make_lane(32'h5, 32'h5, 32'h0),
                make_lane(32'h7fff_ffff, 32'hffff_ffff, 32'h0),
                make_lane(32'h0, 32'h1, 32'h0), make_lane(32'h8000_0000, 32'h1, 32'h0)});
        add_row(1'b1, OP_MUL, 4'hf, {make_lane(32'hffff_fffe, 32'h3, 32'h0),
                make_lane(32'h8000_0000, 32'h2, 32'h0),
                make_lane(32'h0001_0000, 32'h0001_0000, 32'h0),
                make_lane(32'hffff_ffff, 32'hffff_ffff, 32'h0)});
        add_row(1'b1, OP_MACC, 4'hf, {make_lane(32'h0, 32'h0, 32'hdead_beef),
                make_lane(32'h1234, 32'h5678, 32'hffff_ffff),
                make_lane(32'h7fff_ffff, 32'h2, 32'h2), make_lane(32'hffff_ffff, 32'h2, 32'h5)});
        add_row(1'b1, OP_NOP, 4'hf, ramp(32'h10));
        add_row(1'b1, 3'd5, 4'ha, ramp(32'h20));     // spare code
        add_row(1'b1, 3'd7, 4'h5, ramp(32'h30));
        add_row(1'b1, OP_ADD, 4'h5, ramp(32'h40));   // lanes 1 and 3 off
        add_row(1'b1, OP_SUB, 4'h0, ramp(32'h50));   // nothing masked in
        add_row(1'b0, OP_MUL, 4'hf, ramp(32'h60));   // bubble
        add_row(1'b1, OP_MACC, 4'h6, ramp(32'hffff_fff0));
        for (int k = 0; k < N_RAND; k++) begin
            r.vld  = ($urandom_range(0, 7) != 0);   // bubble now and then
            r.op   = 3'($urandom_range(0, 5));      // 5 stands for the spare codes
            r.mask = N_LANES'($urandom);
            for (int i = 0; i < N_LANES; i++) begin
                r.lanes[i] = make_lane($urandom, $urandom, $urandom);
            end
            rows.push_back(r);
        end
    endtask

    // expected outputs from the op rules
    function automatic exp_t model(row_t r);
        exp_t  e;
        logic  arith;
        data_t a;
        data_t b;
        data_t c;
        e     = '0;
        arith = (r.op <= 3'd3);  // add, sub, mul, macc
        for (int i = 0; i < N_LANES; i++) begin
            a = r.lanes[i].a;
            b = r.lanes[i].b;
            c = r.lanes[i].c;
            e.lane_valid[i] = r.vld & r.mask[i];
            e.res_valid[i]  = e.lane_valid[i] & arith;
            e.byp[i]        = a;
            case (r.op)
                3'd0:    e.res[i] = a + b;
                3'd1:    e.res[i] = a - b;
                3'd2:    e.res[i] = a * b;      // low word
                3'd3:    e.res[i] = a * b + c;
                default: e.res[i] = '0;
            endcase
            if (!e.res_valid[i]) begin
                e.res[i] = '0;  // cleared at the output
            end
            e.sum = e.sum + e.res[i];
        end
        e.sum_valid = |e.res_valid;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
        end
    endtask

    task automatic compare_outputs(input exp_t e);
        check_val("o_lane_valid", 32'(o_lane_valid), 32'(e.lane_valid));
        check_val("o_sum_valid", 32'(o_sum_valid), 32'(e.sum_valid));
        for (int i = 0; i < N_LANES; i++) begin
            check_val($sformatf("o_lanes[%0d].res", i), o_lanes[i].res, e.res[i]);
            if (e.lane_valid[i]) begin
                check_val($sformatf("o_lanes[%0d].bypass", i), o_lanes[i].bypass, e.byp[i]);
            end
        end
        if (e.sum_valid) begin
            check_val("o_sum", o_sum, e.sum);
        end
    endtask

    task automatic drive_row(input row_t r);
        i_valid     = r.vld;
        i_op        = op_t'(r.op);
        i_lane_mask = r.mask;
        i_lanes     = r.lanes;
    endtask

    initial begin
        row_t r;
        exp_t e;
        int   tag;
        int   err_before;
        void'($urandom(32'hd965_21a3));  // fixed seed
        i_rst_n     = 1'b0;
        i_valid     = 1'b0;
        i_op        = OP_NOP;
        i_lane_mask = '0;
        i_lanes     = '0;
        n_checks    = 0;
        n_errors    = 0;
        n_tests     = 0;
        build_table();
        for (int k = 0; k < PIPE; k++) begin
            exp_q.push_back('0);  // outputs stay idle right after reset
            tag_q.push_back(-1);
        end
        repeat (5) @(posedge i_clk);
        #1;
        err_before = n_errors;
        check_val("o_lane_valid", 32'(o_lane_valid), 32'h0);
        check_val("o_sum_valid", 32'(o_sum_valid), 32'h0);
        n_tests++;
        if (n_errors == err_before) begin
            $display("reset: valid outputs low, ok");
        end else begin
            $display("reset: a valid output was high during reset");
        end
        i_rst_n = 1'b1;
        for (int j = 0; j < N_ROWS + PIPE; j++) begin
            @(posedge i_clk);
            #1;                      // outputs settled, inputs safe to change
            e          = exp_q.pop_front();
            tag        = tag_q.pop_front();
            err_before = n_errors;
            compare_outputs(e);
            if (tag >= 0) begin
                n_tests++;
                if (n_errors == err_before) begin
                    $display("row %0d op %0d mask %h ok", tag, rows[tag].op, rows[tag].mask);
                end else begin
                    $display("row %0d op %0d mask %h had %0d mismatches", tag,
                             rows[tag].op, rows[tag].mask, n_errors - err_before);
                end
            end else if (n_errors != err_before) begin
                $display("idle cycle %0d showed activity on the outputs", j);
            end
            if (j < N_ROWS) begin
                r = rows[j];
            end else begin
                r = '0;              // table done, drain
            end
            drive_row(r);
            exp_q.push_back(model(r));
            tag_q.push_back((j < N_ROWS) ? j : -1);
        end
        $display("tests %0d, checks %0d, mismatches %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
